/* bench/uart_echo_checker.sv */
// Checker for the echo testbench
// Deserializes the tx pin, compares echo bytes and uart_rx_data against queued values
// The testbench fills the queues through expect_tx_byte and expect_rx_data
`timescale 1ns/1ps
`include "uart_echo_cfg.svh"

module uart_echo_checker (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 uart_tx_port,
    input  uart_line_pkg::char_t uart_rx_data
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    string                tx_name_q[$];     // Test name per echo byte
    uart_line_pkg::char_t tx_exp_q[$];
    string                rx_name_q[$];
    uart_line_pkg::char_t rx_exp_q[$];
    int                   tx_rd_idx = 0;    // Next echo byte to compare
    int                   rx_rd_idx = 0;
    uart_line_pkg::char_t tx_byte;

    int tx_err_cnt   = 0;   // Wrong echo bytes
    int rx_err_cnt   = 0;   // Wrong uart_rx_data
    int extra_cnt    = 0;   // Output with nothing expected
    int stop_err_cnt = 0;

    task automatic expect_tx_byte(input string name, input uart_line_pkg::char_t value);
        tx_name_q.push_back(name);
        tx_exp_q.push_back(value);
    endtask

    task automatic expect_rx_data(input string name, input uart_line_pkg::char_t value);
        rx_name_q.push_back(name);
        rx_exp_q.push_back(value);
    endtask

    function automatic int pending();
        return tx_exp_q.size() - tx_rd_idx;     // Echo bytes not seen yet
    endfunction

    function automatic int error_count();
        return tx_err_cnt + rx_err_cnt + extra_cnt + stop_err_cnt;
    endfunction

    task automatic compare_tx_byte(input uart_line_pkg::char_t actual);
        if (tx_rd_idx >= tx_exp_q.size()) begin
            $display("Error: byte 0x%02h came out on the tx pin with no echo expected", actual);
            extra_cnt++;
        end else begin
            if (actual !== tx_exp_q[tx_rd_idx]) begin
                $display("Fail %s: expected 0x%02h, actual 0x%02h",
                         tx_name_q[tx_rd_idx], tx_exp_q[tx_rd_idx], actual);
                tx_err_cnt++;
            end
            tx_rd_idx++;
        end
    endtask

    ////////////////////////////////////////
    // Tx pin deserializer
    ////////////////////////////////////////
    always begin
        @(negedge sys_clk);
        if (sys_rst_n === 1'b1 && uart_tx_port === 1'b0) begin   // Start bit seen
            repeat (HALF_BIT - 1) @(negedge sys_clk);           // Mid start bit
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge sys_clk);
                tx_byte[i] = uart_tx_port;                      // LSB first
            end
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            if (uart_tx_port !== 1'b1) begin
                $display("Error: tx frame of byte 0x%02h has a low stop bit at %0t ns",
                         tx_byte, $time);
                stop_err_cnt++;
            end
            compare_tx_byte(tx_byte);
        end
    end

    // Last received byte, one check per frame sent
    always @(negedge sys_clk) begin
        if (rx_rd_idx < rx_exp_q.size()) begin
            if (uart_rx_data !== rx_exp_q[rx_rd_idx]) begin
                $display("Fail %s: expected uart_rx_data 0x%02h, actual 0x%02h",
                         rx_name_q[rx_rd_idx], rx_exp_q[rx_rd_idx], uart_rx_data);
                rx_err_cnt++;
            end
            rx_rd_idx++;
        end
    end

endmodule

/* bench/uart_echo_input.txt */
# Record: test <name> [burst], send <hex bytes, ! before a byte gives it a low stop bit>,
# expect <hex bytes of the echo on the tx pin>, end. Burst sends with no idle gaps
test simple_line
    send   68 65 6c 6c 6f 0d
    expect 68 65 6c 6c 6f 0d 0a end
test lf_discarded
    send   61 62 0d 0a
    expect 61 62 0d 0a end
test empty_line
    send   0d
    expect 0d 0a end
test long_line
    send   41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 0d
    expect 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 0d 0a 51 52 53 54 0d 0a end
test back_to_back burst
    send   78 31 0d 79 32 32 0d 7a 33 33 33 0d
    expect 78 31 0d 0a 79 32 32 0d 0a 7a 33 33 33 0d 0a end
test bad_frame
    send   6b !58 6d 0d
    expect 6b 6d 0d 0a end

/* bench/uart_echo_tb.sv */
// Testbench top for the serial line echo unit
// Reads test records from the input data file and sends them on the rx pin frame by frame
// The checker beside the DUT does all comparing
`timescale 1ns/1ps
`include "uart_echo_cfg.svh"

module uart_echo_tb;

    localparam int    CLK_PERIOD_NS = 4;
    localparam int    RESET_CYCLES  = 5;
    localparam int    CLKS_PER_BIT  = `UART_CLKS_PER_BIT;
    localparam string STIM_FILE     = "bench/uart_echo_input.txt";

    logic                 sys_clk = 1'b0;
    logic                 sys_rst_n;
    logic                 uart_rx_port;
    logic                 uart_tx_port;
    uart_line_pkg::char_t uart_rx_data;

    // Test records, flattened per byte
    string                test_names[$];
    bit                   test_burst[$];
    uart_line_pkg::char_t send_data[$];
    bit                   send_bad[$];      // Low stop bit
    int                   send_test[$];     // Record index
    uart_line_pkg::char_t exp_data[$];
    int                   exp_test[$];

    uart_line_pkg::char_t last_good = '0;   // Tracks uart_rx_data, zero out of reset
    int                   seed      = 13;
    bit                   wd_armed  = 1'b0;
    real                  wd_limit_ns;

    always #(CLK_PERIOD_NS / 2) sys_clk = ~sys_clk;

    uart_echo dut (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_rx_port (uart_rx_port),
        .uart_tx_port (uart_tx_port),
        .uart_rx_data (uart_rx_data)
    );

    uart_echo_checker echo_chk (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .uart_tx_port (uart_tx_port),
        .uart_rx_data (uart_rx_data)
    );

    ////////////////////////////////////////
    // Stimulus file parsing
    ////////////////////////////////////////
    task automatic read_token(input int fd, output string tok, output bit eof);
        int ch;
        tok = "";
        ch  = $fgetc(fd);
        while (ch == 32 || ch == 9 || ch == 10 || ch == 13 || ch == 35) begin
            if (ch == 35) begin                         // Comment, skip the line
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end
            if (ch != -1) ch = $fgetc(fd);
        end
        while (ch > 32) begin
            tok = $sformatf("%s%c", tok, ch[7:0]);
            ch  = $fgetc(fd);
        end
        eof = tok.len() == 0;
    endtask

    function automatic int hex_digit(input int code);
        if (code >= 48 && code <= 57)  return code - 48;    // 0-9
        if (code >= 97 && code <= 102) return code - 87;    // a-f
        if (code >= 65 && code <= 70)  return code - 55;    // A-F
        return -1;
    endfunction

    // Two hex digits, optional ! prefix for a bad stop bit
    function automatic bit parse_byte(input string tok, output uart_line_pkg::char_t value,
                                      output bit bad_stop);
        int first;
        int nib;
        bit ok;
        value    = '0;
        bad_stop = (tok.len() > 0) && (tok.getc(0) == 8'h21);
        first    = bad_stop ? 1 : 0;
        ok       = (tok.len() - first) == 2;
        for (int i = first; i < tok.len(); i++) begin
            nib = hex_digit(int'(tok.getc(i)));
            if (nib < 0) ok = 1'b0;
            else         value = {value[3:0], nib[3:0]};
        end
        return ok;
    endfunction

    task automatic load_tests(output bit ok);
        int                   fd;
        int                   mode;     // 0 outside, 1 send bytes, 2 echo bytes
        string                tok;
        bit                   eof;
        bit                   bad;
        bit                   is_byte;
        uart_line_pkg::char_t value;
        ok   = 1'b1;
        mode = 0;
        fd   = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            read_token(fd, tok, eof);
            while (!eof && ok) begin
                is_byte = parse_byte(tok, value, bad);
                if (tok == "test") begin
                    read_token(fd, tok, eof);
                    test_names.push_back(tok);
                    test_burst.push_back(1'b0);
                    mode = 0;
                end else if (tok == "burst" && test_names.size() > 0) begin
                    test_burst[test_burst.size() - 1] = 1'b1;
                end else if (tok == "send" && test_names.size() > 0) begin
                    mode = 1;
                end else if (tok == "expect" && test_names.size() > 0) begin
                    mode = 2;
                end else if (tok == "end") begin
                    mode = 0;
                end else if (is_byte && mode == 1) begin
                    send_data.push_back(value);
                    send_bad.push_back(bad);
                    send_test.push_back(test_names.size() - 1);
                end else if (is_byte && mode == 2 && !bad) begin
                    exp_data.push_back(value);
                    exp_test.push_back(test_names.size() - 1);
                end else begin
                    $display("Error: unexpected token %s in the stimulus file", tok);
                    ok = 1'b0;
                end
                read_token(fd, tok, eof);
            end
            $fclose(fd);
            if (test_names.size() == 0) ok = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Serial stimulus
    ////////////////////////////////////////
    task automatic drive_bit(input logic level);
        @(posedge sys_clk);
        uart_rx_port <= level;
        repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);   // Held one bit time
    endtask

    task automatic send_frame(input uart_line_pkg::char_t data, input bit bad_stop);
        drive_bit(1'b0);                                // Start
        for (int i = 0; i < 8; i++) drive_bit(data[i]);
        drive_bit(!bad_stop);
    endtask

    task automatic idle_gap();
        int gap;
        gap = $random(seed) & 7;                        // 0 to 7 bit times
        repeat (gap) drive_bit(1'b1);
    endtask

    task automatic run_tests();
        int si;
        int ei;
        si = 0;
        ei = 0;
        for (int t = 0; t < test_names.size(); t++) begin
            // Whole echo of the record queued before its first frame
            while (ei < exp_data.size() && exp_test[ei] == t) begin
                echo_chk.expect_tx_byte(test_names[t], exp_data[ei]);
                ei++;
            end
            while (si < send_data.size() && send_test[si] == t) begin
                send_frame(send_data[si], send_bad[si]);
                if (!send_bad[si]) last_good = send_data[si];
                echo_chk.expect_rx_data(test_names[t], last_good);
                if (send_bad[si]) drive_bit(1'b1);      // Line must go high before next start
                if (!test_burst[t]) idle_gap();
                si++;
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: echo %0d, rx data %0d, unexpected output %0d, stop bit %0d, missing %0d",
                 echo_chk.tx_err_cnt, echo_chk.rx_err_cnt, echo_chk.extra_cnt,
                 echo_chk.stop_err_cnt, echo_chk.pending());
    endtask

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////
    initial begin : main
        bit load_ok;
        sys_rst_n    <= 1'b0;
        uart_rx_port <= 1'b1;                           // Idle high
        load_tests(load_ok);
        if (!load_ok) begin
            $display("Error: the stimulus file could not be read or holds no test");
            $display("Simulation failed");
            $finish;
        end else begin
            // Every byte sent or echoed at 10 bits, twice over, plus margin
            wd_limit_ns = real'(send_data.size() + exp_data.size()) * 10.0 * CLKS_PER_BIT
                          * CLK_PERIOD_NS * 2.0 + 10000.0;
            wd_armed = 1'b1;
            repeat (RESET_CYCLES) @(posedge sys_clk);
            sys_rst_n <= 1'b1;
            repeat (2) drive_bit(1'b1);
            run_tests();
            while (echo_chk.pending() != 0) @(posedge sys_clk);
            repeat (30 * CLKS_PER_BIT) @(posedge sys_clk);    // Quiet window for stray bytes
            print_counts();
            if (echo_chk.error_count() == 0 && echo_chk.pending() == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (wd_armed);
        #(wd_limit_ns);
        $display("Error: timeout after %0.0f ns, the echo did not complete", wd_limit_ns);
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+logic
logic/uart_frame_pkg.sv
logic/uart_line_pkg.sv
logic/uart_line_rx.sv
logic/uart_line_buffer.sv
logic/uart_line_tx.sv
logic/uart_echo.sv
bench/uart_echo_checker.sv
bench/uart_echo_tb.sv

/* logic/uart_echo.sv */
// Top of the serial line echo unit
// Received lines are buffered and sent back on the tx pin with CR LF
`timescale 1ns/1ps

module uart_echo (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  logic                 uart_rx_port,
    output logic                 uart_tx_port,
    output uart_line_pkg::char_t uart_rx_data
);

    uart_line_pkg::line_entry_t wr_entry;   // Receiver to buffer
    logic                       wr_en;
    logic                       full;
    uart_line_pkg::line_entry_t rd_entry;   // Buffer head to transmitter
    logic                       rd_en;
    logic                       empty;
    logic                       line_ready;

    ////////////////////////////////////////
    // Receive, store, transmit
    ////////////////////////////////////////
    uart_line_rx ins_uart_line_rx (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .uart_rx_port   (uart_rx_port),
        .full           (full),
        .wr_entry       (wr_entry),
        .wr_en          (wr_en),
        .uart_rx_data   (uart_rx_data)
    );

    uart_line_buffer ins_uart_line_buffer (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .wr_entry       (wr_entry),
        .wr_en          (wr_en),
        .rd_en          (rd_en),
        .rd_entry       (rd_entry),
        .empty          (empty),
        .full           (full),
        .line_ready     (line_ready)
    );

    uart_line_tx ins_uart_line_tx (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .rd_entry       (rd_entry),
        .empty          (empty),
        .line_ready     (line_ready),
        .rd_en          (rd_en),
        .uart_tx_port   (uart_tx_port)
    );

endmodule

/* logic/uart_echo_cfg.svh */
// Build-time settings for the serial line echo unit
// Included by the packages and by every module that needs a rate or a size
`ifndef UART_ECHO_CFG_SVH
`define UART_ECHO_CFG_SVH

////////////////////////////////////////
// Clock and line rate
////////////////////////////////////////
`define UART_CLK_FREQ_HZ    250_000_000   // sys_clk, 4 ns period
`define UART_BAUD_RATE      15_625_000    // Fixed line rate
`define UART_CLKS_PER_BIT   (`UART_CLK_FREQ_HZ / `UART_BAUD_RATE)  // 16 clocks per bit

////////////////////////////////////////
// Line and buffer sizes
////////////////////////////////////////
`define UART_MAX_LINE       16            // Forced end of line after this many chars
// Power of two, at least two full lines plus one
`define UART_BUF_DEPTH      64

`endif

/* logic/uart_frame_pkg.sv */
// Types for the serial side of the echo unit
// Bit timing counters and the receive and transmit state machines
`include "uart_echo_cfg.svh"

package uart_frame_pkg;

    // Counts clocks inside one bit period
    typedef logic [$clog2(`UART_CLKS_PER_BIT + 1) - 1:0] baud_cnt_t;

    typedef logic [2:0] bit_idx_t;      // Data bit 0..7, LSB first

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE,    // Waiting for a falling edge
        RX_START,   // Checking start bit at mid-bit
        RX_DATA,    // Sampling 8 data bits
        RX_STOP     // Stop bit must read high
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

endpackage

/* logic/uart_line_buffer.sv */
// Circular character store between receiver and transmitter
// Tracks complete lines so a line is only sent once its end has arrived
`timescale 1ns/1ps
`include "uart_echo_cfg.svh"

module uart_line_buffer (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  uart_line_pkg::line_entry_t wr_entry,
    input  logic                       wr_en,
    input  logic                       rd_en,
    output uart_line_pkg::line_entry_t rd_entry,
    output logic                       empty,
    output logic                       full,
    output logic                       line_ready
);

    localparam int DEPTH = `UART_BUF_DEPTH;

    uart_line_pkg::line_entry_t mem [DEPTH];
    uart_line_pkg::buf_ptr_t    wr_ptr;
    uart_line_pkg::buf_ptr_t    rd_ptr;
    uart_line_pkg::line_cnt_t   occupancy;          // Entries held
    uart_line_pkg::line_cnt_t   line_cnt;           // Complete lines held
    logic                       do_wr;
    logic                       do_rd;
    logic                       line_in;
    logic                       line_out;

    assign do_wr      = wr_en && !full;
    assign do_rd      = rd_en && !empty;
    assign line_in    = do_wr && wr_entry.eol;
    assign line_out   = do_rd && rd_entry.eol;
    assign full       = occupancy == uart_line_pkg::line_cnt_t'(DEPTH);
    assign empty      = occupancy == '0;
    assign rd_entry   = mem[rd_ptr];                 // Head, valid while !empty
    assign line_ready = line_cnt != '0;

    always_ff @(posedge sys_clk) begin
        if (do_wr) mem[wr_ptr] <= wr_entry;
    end

    ////////////////////////////////////////
    // Pointers and counters
    ////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            line_cnt  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;     // Wraps, depth is a power of two
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: ;
            endcase
            case ({line_in, line_out})              // Same-cycle in and out cancel
                2'b10:   line_cnt <= line_cnt + 1'b1;
                2'b01:   line_cnt <= line_cnt - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* logic/uart_line_pkg.sv */
// Types for the character side of the echo unit
// Used between the receiver, the line buffer and the transmitter
`include "uart_echo_cfg.svh"

package uart_line_pkg;

    typedef logic [7:0] char_t;

    localparam char_t CHAR_CR = 8'h0D;  // Ends a line, also the empty-line marker
    localparam char_t CHAR_LF = 8'h0A;  // Discarded on input

    // One buffer slot
    typedef struct packed {
        char_t ch;      // Payload, not sent when it is the CR marker
        logic  eol;     // Last entry of a line
    } line_entry_t;

    typedef logic [$clog2(`UART_BUF_DEPTH) - 1:0]     buf_ptr_t;   // Slot address
    typedef logic [$clog2(`UART_BUF_DEPTH + 1) - 1:0] line_cnt_t;  // 0..DEPTH
    typedef logic [$clog2(`UART_MAX_LINE + 1) - 1:0]  line_len_t;  // Chars in open line

endpackage

/* logic/uart_line_rx.sv */
// UART receiver that turns the rx pin into line buffer entries
// CR closes a line, LF is dropped, long lines are split at UART_MAX_LINE
`timescale 1ns/1ps
`include "uart_echo_cfg.svh"

module uart_line_rx (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       uart_rx_port,
    input  logic                       full,
    output uart_line_pkg::line_entry_t wr_entry,
    output logic                       wr_en,
    output uart_line_pkg::char_t       uart_rx_data
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    logic [2:0]                rx_sync;     // [1:0] synchronizer, [2] previous level
    logic                      rx_pin;
    logic                      start_edge;
    logic                      half_end;
    logic                      bit_end;
    logic                      stop_good;
    logic                      line_done;
    uart_frame_pkg::rx_state_e state;
    uart_frame_pkg::baud_cnt_t baud_cnt;
    uart_frame_pkg::bit_idx_t  bit_idx;
    uart_line_pkg::char_t      shift_reg;
    uart_line_pkg::line_len_t  line_len;

    ////////////////////////////////////////
    // Pin synchronizer
    ////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            rx_sync <= '1;                                  // Line idles high
        end else begin
            rx_sync <= {rx_sync[1:0], uart_rx_port};
        end
    end

    assign rx_pin     = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];       // High to low only
    assign half_end   = baud_cnt == uart_frame_pkg::baud_cnt_t'(HALF_BIT - 1);
    assign bit_end    = baud_cnt == uart_frame_pkg::baud_cnt_t'(CLKS_PER_BIT - 1);
    assign stop_good  = (state == uart_frame_pkg::RX_STOP) && bit_end && rx_pin;
    assign line_done  = line_len == uart_line_pkg::line_len_t'(`UART_MAX_LINE - 1);

    ////////////////////////////////////////
    // Deframing FSM
    ////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state    <= uart_frame_pkg::RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            case (state)
                uart_frame_pkg::RX_IDLE: begin
                    baud_cnt <= '0;
                    if (start_edge) state <= uart_frame_pkg::RX_START;
                end
                uart_frame_pkg::RX_START: begin
                    if (half_end) begin                     // Mid start bit
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_pin ? uart_frame_pkg::RX_IDLE    // Glitch
                                           : uart_frame_pkg::RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_frame_pkg::RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= uart_frame_pkg::RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_frame_pkg::RX_STOP: begin
                    // Bad stop bit just falls back to idle
                    if (bit_end) state <= uart_frame_pkg::RX_IDLE;
                    else         baud_cnt <= baud_cnt + 1'b1;
                end
                default: state <= uart_frame_pkg::RX_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge sys_clk) begin
        if (state == uart_frame_pkg::RX_DATA && bit_end) shift_reg <= {rx_pin, shift_reg[7:1]};
    end

    ////////////////////////////////////////
    // Line assembly
    ////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            wr_en        <= 1'b0;
            uart_rx_data <= '0;
            line_len     <= '0;
        end else begin
            wr_en <= 1'b0;                                  // Strobe
            if (stop_good) begin
                uart_rx_data <= shift_reg;                  // Every good byte, CR and LF too
                if (shift_reg == uart_line_pkg::CHAR_CR) begin
                    wr_en    <= !full;                      // End-of-line marker
                    line_len <= '0;
                end else if (shift_reg != uart_line_pkg::CHAR_LF && !full) begin
                    wr_en    <= 1'b1;
                    line_len <= line_done ? '0 : line_len + 1'b1;   // Forced split
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (stop_good) begin
            wr_entry.ch  <= shift_reg;
            wr_entry.eol <= (shift_reg == uart_line_pkg::CHAR_CR) || line_done;
        end
    end

endmodule

/* logic/uart_line_tx.sv */
// UART transmitter that drains one complete line at a time from the buffer
// Sends the line characters, then CR LF, then looks for the next line
`timescale 1ns/1ps
`include "uart_echo_cfg.svh"

module uart_line_tx (
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  uart_line_pkg::line_entry_t rd_entry,
    input  logic                       empty,
    input  logic                       line_ready,
    output logic                       rd_en,
    output logic                       uart_tx_port
);

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;

    // Source of the next byte
    typedef enum logic [1:0] {
        SEQ_CHAR,   // From the buffer
        SEQ_CR,
        SEQ_LF
    } seq_e;

    uart_frame_pkg::tx_state_e state;
    uart_frame_pkg::baud_cnt_t baud_cnt;
    uart_frame_pkg::bit_idx_t  bit_idx;
    uart_line_pkg::char_t      shift_reg;
    uart_line_pkg::char_t      next_byte;
    seq_e                      seq;
    seq_e                      next_seq;
    logic                      launch;
    logic                      pop;
    logic                      bit_end;
    logic                      shift_out;

    assign bit_end   = baud_cnt == uart_frame_pkg::baud_cnt_t'(CLKS_PER_BIT - 1);
    assign shift_out = bit_end && (state == uart_frame_pkg::TX_START ||
                       (state == uart_frame_pkg::TX_DATA && bit_idx != 3'd7));

    ////////////////////////////////////////
    // Byte sequencer
    ////////////////////////////////////////
    always_comb begin
        launch    = 1'b0;
        pop       = 1'b0;
        next_byte = uart_line_pkg::CHAR_CR;
        next_seq  = seq;
        case (seq)
            SEQ_CHAR: begin
                if (line_ready && !empty) begin     // Whole line is in the buffer
                    launch = 1'b1;
                    pop    = 1'b1;
                    if (rd_entry.ch == uart_line_pkg::CHAR_CR) begin
                        next_seq = SEQ_LF;          // Marker, CR goes out now
                    end else begin
                        next_byte = rd_entry.ch;
                        next_seq  = rd_entry.eol ? SEQ_CR : SEQ_CHAR;
                    end
                end
            end
            SEQ_CR: begin
                launch   = 1'b1;
                next_seq = SEQ_LF;
            end
            SEQ_LF: begin
                launch    = 1'b1;
                next_byte = uart_line_pkg::CHAR_LF;
                next_seq  = SEQ_CHAR;               // Line finished
            end
            default: next_seq = SEQ_CHAR;
        endcase
    end

    ////////////////////////////////////////
    // Serializer FSM
    ////////////////////////////////////////
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            state        <= uart_frame_pkg::TX_IDLE;
            seq          <= SEQ_CHAR;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            rd_en        <= 1'b0;
            uart_tx_port <= 1'b1;                       // Idle high
        end else begin
            rd_en <= 1'b0;
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                uart_frame_pkg::TX_IDLE: begin
                    baud_cnt <= '0;
                    if (launch) begin
                        uart_tx_port <= 1'b0;           // Start bit
                        rd_en        <= pop;            // Pop as the frame starts
                        seq          <= next_seq;
                        state        <= uart_frame_pkg::TX_START;
                    end
                end
                uart_frame_pkg::TX_START: begin
                    if (bit_end) begin
                        bit_idx      <= '0;
                        uart_tx_port <= shift_reg[0];
                        state        <= uart_frame_pkg::TX_DATA;
                    end
                end
                uart_frame_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            uart_tx_port <= 1'b1;       // Stop bit
                            state        <= uart_frame_pkg::TX_STOP;
                        end else begin
                            uart_tx_port <= shift_reg[0];
                        end
                    end
                end
                uart_frame_pkg::TX_STOP: begin
                    if (bit_end) state <= uart_frame_pkg::TX_IDLE;
                end
                default: state <= uart_frame_pkg::TX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge sys_clk) begin
        if (state == uart_frame_pkg::TX_IDLE && launch) shift_reg <= next_byte;
        else if (shift_out)                              shift_reg <= shift_reg >> 1;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the echo testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module uart_echo_tb \
    -Mdir obj_dir -f filelist.f || exit 1
sim_out=$(./obj_dir/Vuart_echo_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "^Simulation completed successfully$" && exit 0 || exit 1
